// ==== sim.f ====
source/rename_params_pkg.sv
source/rename_types_pkg.sv
source/map_tables.sv
source/free_list.sv
source/ready_list.sv
source/rename_unit.sv
test/rename_unit_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile the rename stage testbench with Verilator and run it.
# The exit status follows the search for the pass message in the output.
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module rename_unit_tb -Mdir obj_dir -f sim.f &&
./obj_dir/Vrename_unit_tb | tee /dev/stderr | grep -q '^>>> PASS$' &&
echo "Simulation passed" && exit 0 ||
{ echo "Simulation failed"; exit 1; }

// ==== test/rename_unit_tb.sv ====
/*
 * Rename stage testbench
 * Directed tests of lookup, allocation, exhaustion, commit release and recovery
 */
module rename_unit_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import rename_params_pkg::*;
    import rename_types_pkg::*;

    typedef arch_idx_t [RENAME_WAYS-1:0] arch_group_t;
    typedef phys_idx_t [RENAME_WAYS-1:0] phys_group_t;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 5;
    localparam int SEED         = 32'h21eeef20;
    // Five resets plus the cycles of each test in order
    localparam int TEST_CYCLES  = 5 * (RESET_CYCLES + 1) + 32 + 4 + 10 + 13 + 37;
    localparam int TIMEOUT_NS   = (TEST_CYCLES + 50) * CLK_PERIOD;

    logic        clock;
    logic        reset;
    logic        except;
    arch_group_t dest_idx;
    way_mask_t   rename_en;
    arch_group_t src_a_idx;
    arch_group_t src_b_idx;
    phys_group_t cdb_idx;
    way_mask_t   cdb_en;
    arch_group_t commit_arch_idx;
    phys_group_t commit_phys_idx;
    way_mask_t   commit_en;
    phys_group_t rename_phys_idx;
    way_mask_t   rename_valid;
    phys_group_t src_a_phys;
    phys_group_t src_b_phys;
    way_mask_t   src_a_ready;
    way_mask_t   src_b_ready;

    integer      seed;
    phys_idx_t   model_rrat [ARCH_REGS];    // Expected retirement map
    phys_mask_t  model_ret_free;            // Expected retirement free mask

    rename_unit u_dut (
        .clock           (clock),
        .reset           (reset),
        .except          (except),
        .dest_idx        (dest_idx),
        .rename_en       (rename_en),
        .src_a_idx       (src_a_idx),
        .src_b_idx       (src_b_idx),
        .cdb_idx         (cdb_idx),
        .cdb_en          (cdb_en),
        .commit_arch_idx (commit_arch_idx),
        .commit_phys_idx (commit_phys_idx),
        .commit_en       (commit_en),
        .rename_phys_idx (rename_phys_idx),
        .rename_valid    (rename_valid),
        .src_a_phys      (src_a_phys),
        .src_b_phys      (src_b_phys),
        .src_a_ready     (src_a_ready),
        .src_b_ready     (src_b_ready)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
            $display(">>> FAIL");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic idle_inputs();
        rename_en <= '0;
        cdb_en    <= '0;
        commit_en <= '0;
        except    <= 1'b0;
    endtask

    task automatic apply_reset();
        @(posedge clock);
        idle_inputs();
        reset <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;
        model_ret_free = '0;
        for (int i = ARCH_REGS; i < PHYS_REGS; i++) begin
            model_ret_free[i] = 1'b1;       // Upper half starts free
        end
        for (int i = 0; i < ARCH_REGS; i++) begin
            model_rrat[i] = phys_idx_t'(i);
        end
    endtask

    function automatic phys_group_t consecutive(input int base);
        phys_group_t grp;
        for (int w = 0; w < RENAME_WAYS; w++) begin
            grp[w] = phys_idx_t'(base + w);
        end
        return grp;
    endfunction

    function automatic arch_group_t random_dests();
        arch_group_t grp;
        for (int w = 0; w < RENAME_WAYS; w++) begin
            grp[w] = arch_idx_t'($random(seed));
        end
        return grp;
    endfunction

    task automatic rename_group(input way_mask_t en, input way_mask_t exp_valid,
                                input phys_group_t exp_idx, input arch_group_t dests);
        @(posedge clock);
        idle_inputs();
        rename_en <= en;
        dest_idx  <= dests;
        @(negedge clock);
        check_value("rename_valid", 64'(rename_valid), 64'(exp_valid));
        for (int w = 0; w < RENAME_WAYS; w++) begin
            if (exp_valid[w]) begin
                check_value($sformatf("rename_phys_idx[%0d]", w),
                            64'(rename_phys_idx[w]), 64'(exp_idx[w]));
            end
        end
    endtask

    task automatic commit_group(input way_mask_t en, input arch_group_t arch,
                                input phys_group_t phys, input logic exc);
        @(posedge clock);
        idle_inputs();
        commit_en       <= en;
        commit_arch_idx <= arch;
        commit_phys_idx <= phys;
        except          <= exc;
        for (int w = 0; w < RENAME_WAYS; w++) begin
            if (en[w]) begin
                model_ret_free[model_rrat[arch[w]]] = 1'b1;    // Displaced mapping
                model_ret_free[phys[w]] = 1'b0;
                model_rrat[arch[w]] = phys[w];
            end
        end
    endtask

    task automatic lookup_check(input arch_group_t a_idx, input arch_group_t b_idx,
                                input phys_group_t exp_a, input phys_group_t exp_b,
                                input way_mask_t ready_a, input way_mask_t ready_b);
        @(posedge clock);
        idle_inputs();
        src_a_idx <= a_idx;
        src_b_idx <= b_idx;
        @(negedge clock);
        for (int w = 0; w < RENAME_WAYS; w++) begin
            check_value($sformatf("src_a_phys[%0d]", w), 64'(src_a_phys[w]), 64'(exp_a[w]));
            check_value($sformatf("src_b_phys[%0d]", w), 64'(src_b_phys[w]), 64'(exp_b[w]));
        end
        check_value("src_a_ready", 64'(src_a_ready), 64'(ready_a));
        check_value("src_b_ready", 64'(src_b_ready), 64'(ready_b));
        check_value("rename_valid", 64'(rename_valid), 64'(0));
    endtask

    // Every architectural register on every way checked against the retirement map
    task automatic lookup_all();
        arch_group_t a_idx;
        arch_group_t b_idx;
        phys_group_t exp_a;
        phys_group_t exp_b;
        for (int i = 0; i < ARCH_REGS; i++) begin
            for (int w = 0; w < RENAME_WAYS; w++) begin
                a_idx[w] = arch_idx_t'(i);
                b_idx[w] = arch_idx_t'(i + 7 * w + 3);
                exp_a[w] = model_rrat[a_idx[w]];
                exp_b[w] = model_rrat[b_idx[w]];
            end
            lookup_check(a_idx, b_idx, exp_a, exp_b, '1, '1);
        end
    endtask

    task automatic test_reset_state();
        $display("Test: reset state");
        apply_reset();
        lookup_all();
    endtask

    task automatic test_alloc_ready();
        arch_group_t dests;
        phys_group_t exp_phys;
        way_mask_t   exp_ready;
        phys_idx_t   target;
        int          winner;
        $display("Test: allocation and readiness");
        apply_reset();
        dests = random_dests();
        dests[2] = dests[0];                // At least one shared destination
        rename_group('1, '1, consecutive(ARCH_REGS), dests);
        for (int w = 0; w < RENAME_WAYS; w++) begin
            winner = w;
            for (int v = w + 1; v < RENAME_WAYS; v++) begin
                if (dests[v] == dests[w]) begin
                    winner = v;             // Highest way owns the mapping
                end
            end
            exp_phys[w] = phys_idx_t'(ARCH_REGS + winner);
        end
        lookup_check(dests, dests, exp_phys, exp_phys, '0, '0);
        target = exp_phys[0];
        @(posedge clock);
        idle_inputs();
        cdb_idx[2] <= target;
        cdb_en     <= 4'b0100;
        @(negedge clock);
        check_value("src_a_ready", 64'(src_a_ready), 64'(0));   // Not before next cycle
        for (int w = 0; w < RENAME_WAYS; w++) begin
            exp_ready[w] = (exp_phys[w] == target);
        end
        lookup_check(dests, dests, exp_phys, exp_phys, exp_ready, exp_ready);
    endtask

    task automatic test_exhaustion();
        $display("Test: free list exhaustion");
        apply_reset();
        for (int g = 0; g < 7; g++) begin
            rename_group('1, '1, consecutive(ARCH_REGS + 4 * g), random_dests());
        end
        rename_group(4'b0111, 4'b0111, consecutive(60), random_dests());
        rename_group(4'b1110, 4'b0010, consecutive(62), random_dests());     // One left
        rename_group('1, '0, consecutive(0), random_dests());
    endtask

    task automatic test_commit_release();
        arch_group_t arch;
        phys_group_t exp_phys;
        $display("Test: commit and release");
        apply_reset();
        arch = '0;
        arch[0] = 5'd5;
        arch[1] = 5'd5;
        rename_group(4'b0011, 4'b0011, consecutive(32), arch);
        for (int g = 0; g < 7; g++) begin
            rename_group('1, '1, consecutive(34 + 4 * g), random_dests());
        end
        rename_group(4'b0011, 4'b0011, consecutive(62), random_dests());
        rename_group('1, '0, consecutive(0), random_dests());
        commit_group(4'b0011, arch, consecutive(32), 1'b0);
        exp_phys = '0;
        exp_phys[0] = 6'd5;                 // Old RRAT entry
        exp_phys[1] = 6'd32;                // Way 0 mapping displaced by way 1
        rename_group('1, 4'b0011, exp_phys, random_dests());
        rename_group('1, '0, consecutive(0), random_dests());
    endtask

    task automatic test_exception_recovery();
        arch_group_t dests;
        arch_group_t arch;
        phys_group_t phys;
        phys_group_t exp_phys;
        int          cnt;
        $display("Test: exception recovery");
        apply_reset();
        dests = {5'd4, 5'd3, 5'd2, 5'd1};
        rename_group('1, '1, consecutive(32), dests);
        dests = {5'd8, 5'd7, 5'd6, 5'd1};
        rename_group('1, '1, consecutive(36), dests);
        arch = {5'd0, 5'd0, 5'd2, 5'd1};
        commit_group(4'b0011, arch, consecutive(32), 1'b0);
        arch = '0;
        arch[0] = 5'd3;
        phys = '0;
        phys[0] = 6'd34;
        commit_group(4'b0001, arch, phys, 1'b1);    // Commit lands with the flush
        lookup_all();
        exp_phys = '0;
        cnt = 0;
        for (int p = 0; p < PHYS_REGS; p++) begin
            if (model_ret_free[p] && (cnt < RENAME_WAYS)) begin
                exp_phys[cnt] = phys_idx_t'(p);
                cnt++;
            end
        end
        rename_group('1, '1, exp_phys, random_dests());
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the rename tests did not finish within %0d ns", TIMEOUT_NS);
        $display(">>> FAIL");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        clock           = 1'b0;
        seed            = SEED;
        reset           <= 1'b1;
        dest_idx        <= '0;
        src_a_idx       <= '0;
        src_b_idx       <= '0;
        cdb_idx         <= '0;
        commit_arch_idx <= '0;
        commit_phys_idx <= '0;
        idle_inputs();

        test_reset_state();
        test_alloc_ready();
        test_exhaustion();
        test_commit_release();
        test_exception_recovery();

        @(posedge clock);
        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== source/rename_unit.sv ====
/*
 * Register rename stage of a four-wide core
 * Connects the map tables, free list and ready list
 */
module rename_unit (
    input  logic                                                    clock,
    input  logic                                                    reset,
    input  logic                                                    except,

    input  rename_types_pkg::arch_idx_t [rename_params_pkg::RENAME_WAYS-1:0] dest_idx,
    input  rename_types_pkg::way_mask_t                             rename_en,
    input  rename_types_pkg::arch_idx_t [rename_params_pkg::RENAME_WAYS-1:0] src_a_idx,
    input  rename_types_pkg::arch_idx_t [rename_params_pkg::RENAME_WAYS-1:0] src_b_idx,

    input  rename_types_pkg::phys_idx_t [rename_params_pkg::RENAME_WAYS-1:0] cdb_idx,
    input  rename_types_pkg::way_mask_t                             cdb_en,

    input  rename_types_pkg::arch_idx_t [rename_params_pkg::RENAME_WAYS-1:0] commit_arch_idx,
    input  rename_types_pkg::phys_idx_t [rename_params_pkg::RENAME_WAYS-1:0] commit_phys_idx,
    input  rename_types_pkg::way_mask_t                             commit_en,

    output rename_types_pkg::phys_idx_t [rename_params_pkg::RENAME_WAYS-1:0] rename_phys_idx,
    output rename_types_pkg::way_mask_t                             rename_valid,

    output rename_types_pkg::phys_idx_t [rename_params_pkg::RENAME_WAYS-1:0] src_a_phys,
    output rename_types_pkg::phys_idx_t [rename_params_pkg::RENAME_WAYS-1:0] src_b_phys,
    output rename_types_pkg::way_mask_t                             src_a_ready,
    output rename_types_pkg::way_mask_t                             src_b_ready
);
    import rename_params_pkg::*;
    import rename_types_pkg::*;

    phys_idx_t [RENAME_WAYS-1:0] alloc_idx;         // Granted registers
    way_mask_t                   alloc_valid;
    phys_idx_t [RENAME_WAYS-1:0] retire_old_idx;    // Displaced at commit

    assign rename_phys_idx = alloc_idx;
    assign rename_valid    = alloc_valid;

    map_tables u_map_tables (
        .clock           (clock),
        .reset           (reset),
        .except          (except),
        .src_a_idx       (src_a_idx),
        .src_b_idx       (src_b_idx),
        .dest_idx        (dest_idx),
        .alloc_idx       (alloc_idx),
        .alloc_valid     (alloc_valid),
        .commit_arch_idx (commit_arch_idx),
        .commit_phys_idx (commit_phys_idx),
        .commit_en       (commit_en),
        .src_a_phys      (src_a_phys),
        .src_b_phys      (src_b_phys),
        .retire_old_idx  (retire_old_idx)
    );

    free_list u_free_list (
        .clock           (clock),
        .reset           (reset),
        .except          (except),
        .rename_en       (rename_en),
        .commit_phys_idx (commit_phys_idx),
        .commit_en       (commit_en),
        .retire_old_idx  (retire_old_idx),
        .alloc_idx       (alloc_idx),
        .alloc_valid     (alloc_valid)
    );

    ready_list u_ready_list (
        .clock       (clock),
        .reset       (reset),
        .except      (except),
        .src_a_phys  (src_a_phys),
        .src_b_phys  (src_b_phys),
        .alloc_idx   (alloc_idx),
        .alloc_valid (alloc_valid),
        .cdb_idx     (cdb_idx),
        .cdb_en      (cdb_en),
        .src_a_ready (src_a_ready),
        .src_b_ready (src_b_ready)
    );

endmodule

// ==== source/ready_list.sv ====
/*
 * Physical register ready list
 * Set by the CDB, cleared at allocation, looked up for every source
 */
module ready_list (
    input  logic                                                    clock,
    input  logic                                                    reset,
    input  logic                                                    except,

    input  rename_types_pkg::phys_idx_t [rename_params_pkg::RENAME_WAYS-1:0] src_a_phys,
    input  rename_types_pkg::phys_idx_t [rename_params_pkg::RENAME_WAYS-1:0] src_b_phys,

    input  rename_types_pkg::phys_idx_t [rename_params_pkg::RENAME_WAYS-1:0] alloc_idx,
    input  rename_types_pkg::way_mask_t                             alloc_valid,

    input  rename_types_pkg::phys_idx_t [rename_params_pkg::RENAME_WAYS-1:0] cdb_idx,
    input  rename_types_pkg::way_mask_t                             cdb_en,

    output rename_types_pkg::way_mask_t                             src_a_ready,
    output rename_types_pkg::way_mask_t                             src_b_ready
);
    import rename_params_pkg::*;
    import rename_types_pkg::*;

    phys_mask_t ready_q;
    phys_mask_t ready_next;

    always_comb begin
        for (int w = 0; w < RENAME_WAYS; w++) begin
            src_a_ready[w] = ready_q[src_a_phys[w]];
            src_b_ready[w] = ready_q[src_b_phys[w]];
        end
    end

    // Clears are applied last so a fresh allocation always reads not ready
    always_comb begin
        ready_next = ready_q;
        for (int w = 0; w < RENAME_WAYS; w++) begin
            if (cdb_en[w]) begin
                ready_next[cdb_idx[w]] = 1'b1;
            end
        end
        for (int w = 0; w < RENAME_WAYS; w++) begin
            if (alloc_valid[w]) begin
                ready_next[alloc_idx[w]] = 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            ready_q <= {{(PHYS_REGS - ARCH_REGS){1'b0}}, {ARCH_REGS{1'b1}}};
        end else if (except) begin
            // Every retired mapping has already produced its value
            ready_q <= '1;
        end else begin
            ready_q <= ready_next;
        end
    end

endmodule

// ==== source/free_list.sv ====
/*
 * Physical register free list
 * Speculative and retirement free masks with in-order allocation per group
 */
module free_list (
    input  logic                                                    clock,
    input  logic                                                    reset,
    input  logic                                                    except,

    input  rename_types_pkg::way_mask_t                             rename_en,

    input  rename_types_pkg::phys_idx_t [rename_params_pkg::RENAME_WAYS-1:0] commit_phys_idx,
    input  rename_types_pkg::way_mask_t                             commit_en,
    input  rename_types_pkg::phys_idx_t [rename_params_pkg::RENAME_WAYS-1:0] retire_old_idx,

    output rename_types_pkg::phys_idx_t [rename_params_pkg::RENAME_WAYS-1:0] alloc_idx,
    output rename_types_pkg::way_mask_t                             alloc_valid
);
    import rename_params_pkg::*;
    import rename_types_pkg::*;

    phys_mask_t spec_free_q;        // Free as seen by the front end
    phys_mask_t ret_free_q;         // Free as seen by retired state
    phys_mask_t avail;              // What is left after lower ways are served
    phys_mask_t spec_free_next;
    phys_mask_t ret_free_next;

    // Index of the lowest set bit, zero for an empty mask
    function automatic phys_idx_t lowest_set(input phys_mask_t mask);
        phys_idx_t idx;
        idx = '0;
        for (int i = PHYS_REGS - 1; i >= 0; i--) begin
            if (mask[i]) begin
                idx = phys_idx_t'(i);
            end
        end
        return idx;
    endfunction

    // Ways are served from way 0 up, each from what lower ways left over
    always_comb begin
        avail = spec_free_q;
        for (int w = 0; w < RENAME_WAYS; w++) begin
            alloc_idx[w]   = lowest_set(avail);
            alloc_valid[w] = rename_en[w] && (|avail);
            if (alloc_valid[w]) begin
                avail[alloc_idx[w]] = 1'b0;     // Not offered to higher ways
            end
        end
    end

    /*
     * Within a group the clear of a commit's new register comes before the
     * set of a later way's displaced register, so a forwarded one ends free
     */
    always_comb begin
        spec_free_next = avail;
        ret_free_next  = ret_free_q;
        for (int w = 0; w < RENAME_WAYS; w++) begin
            if (commit_en[w]) begin
                spec_free_next[retire_old_idx[w]] = 1'b1;
                ret_free_next[commit_phys_idx[w]] = 1'b0;
                ret_free_next[retire_old_idx[w]]  = 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            spec_free_q <= {{(PHYS_REGS - ARCH_REGS){1'b1}}, {ARCH_REGS{1'b0}}};
            ret_free_q  <= {{(PHYS_REGS - ARCH_REGS){1'b1}}, {ARCH_REGS{1'b0}}};
        end else begin
            ret_free_q <= ret_free_next;
            if (except) begin
                spec_free_q <= ret_free_next;   // Allocations of this cycle dropped
            end else begin
                spec_free_q <= spec_free_next;
            end
        end
    end

endmodule

// ==== source/map_tables.sv ====
/*
 * Speculative and retirement map tables
 * Source lookup, in-group commit forwarding and recovery on exception
 */
module map_tables (
    input  logic                                                    clock,
    input  logic                                                    reset,
    input  logic                                                    except,

    input  rename_types_pkg::arch_idx_t [rename_params_pkg::RENAME_WAYS-1:0] src_a_idx,
    input  rename_types_pkg::arch_idx_t [rename_params_pkg::RENAME_WAYS-1:0] src_b_idx,
    input  rename_types_pkg::arch_idx_t [rename_params_pkg::RENAME_WAYS-1:0] dest_idx,

    input  rename_types_pkg::phys_idx_t [rename_params_pkg::RENAME_WAYS-1:0] alloc_idx,
    input  rename_types_pkg::way_mask_t                             alloc_valid,

    input  rename_types_pkg::arch_idx_t [rename_params_pkg::RENAME_WAYS-1:0] commit_arch_idx,
    input  rename_types_pkg::phys_idx_t [rename_params_pkg::RENAME_WAYS-1:0] commit_phys_idx,
    input  rename_types_pkg::way_mask_t                             commit_en,

    output rename_types_pkg::phys_idx_t [rename_params_pkg::RENAME_WAYS-1:0] src_a_phys,
    output rename_types_pkg::phys_idx_t [rename_params_pkg::RENAME_WAYS-1:0] src_b_phys,
    output rename_types_pkg::phys_idx_t [rename_params_pkg::RENAME_WAYS-1:0] retire_old_idx
);
    import rename_params_pkg::*;
    import rename_types_pkg::*;

    phys_idx_t [ARCH_REGS-1:0] rat_q;       // Front end view
    phys_idx_t [ARCH_REGS-1:0] rat_next;
    phys_idx_t [ARCH_REGS-1:0] rrat_q;      // Committed view
    phys_idx_t [ARCH_REGS-1:0] rrat_next;

    // Lookups read the table as it stood at the start of the cycle
    always_comb begin
        for (int w = 0; w < RENAME_WAYS; w++) begin
            src_a_phys[w] = rat_q[src_a_idx[w]];
            src_b_phys[w] = rat_q[src_b_idx[w]];
        end
    end

    // Later ways overwrite earlier ones on a shared destination
    always_comb begin
        rat_next = rat_q;
        for (int w = 0; w < RENAME_WAYS; w++) begin
            if (alloc_valid[w]) begin
                rat_next[dest_idx[w]] = alloc_idx[w];
            end
        end
    end

    /*
     * A committing way displaces the RRAT entry, unless a lower way of the
     * same group already replaced it; the nearest such lower way wins
     */
    always_comb begin
        for (int w = 0; w < RENAME_WAYS; w++) begin
            retire_old_idx[w] = rrat_q[commit_arch_idx[w]];
            for (int j = 0; j < w; j++) begin
                if (commit_en[j] && (commit_arch_idx[j] == commit_arch_idx[w])) begin
                    retire_old_idx[w] = commit_phys_idx[j];
                end
            end
        end
    end

    always_comb begin
        rrat_next = rrat_q;
        for (int w = 0; w < RENAME_WAYS; w++) begin
            if (commit_en[w]) begin
                rrat_next[commit_arch_idx[w]] = commit_phys_idx[w];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                rat_q[i]  <= phys_idx_t'(i);    // Identity mapping
                rrat_q[i] <= phys_idx_t'(i);
            end
        end else begin
            rrat_q <= rrat_next;                // Commits apply even under except
            if (except) begin
                rat_q <= rrat_next;             // Drop all speculative mappings
            end else begin
                rat_q <= rat_next;
            end
        end
    end

endmodule

// ==== source/rename_types_pkg.sv ====
/*
 * Rename stage types
 * Register indices and bit masks used across the rename stage
 */
package rename_types_pkg;

    typedef logic [rename_params_pkg::ARCH_IDX_BITS-1:0] arch_idx_t;   // Architectural register
    typedef logic [rename_params_pkg::PHYS_IDX_BITS-1:0] phys_idx_t;   // Physical register

    // One bit per rename or commit way
    typedef logic [rename_params_pkg::RENAME_WAYS-1:0] way_mask_t;

    // One bit per physical register
    typedef logic [rename_params_pkg::PHYS_REGS-1:0] phys_mask_t;

endpackage

// ==== source/rename_params_pkg.sv ====
/*
 * Rename stage sizing
 * Widths and counts shared by the map tables, free list and ready list
 */
package rename_params_pkg;

    // Rename and commit group width
    localparam int RENAME_WAYS = 4;

    localparam int ARCH_REGS = 32;      // Architectural register file size
    localparam int PHYS_REGS = 64;      // Physical register file size

    localparam int ARCH_IDX_BITS = 5;   // log2 of ARCH_REGS
    localparam int PHYS_IDX_BITS = 6;   // log2 of PHYS_REGS

endpackage
